/* hw/modexp_macros.svh */
`ifndef MODEXP_MACROS_SVH
`define MODEXP_MACROS_SVH

// ----------------------------------------------------------------------
// word widths
// ----------------------------------------------------------------------

// residue word
`define MODEXP_OPW 16

// exponent word, scanned one bit per ladder round
`define MODEXP_EXPW 16

// ----------------------------------------------------------------------
// modulus and its Montgomery constant
// ----------------------------------------------------------------------

// odd, largest 16-bit prime
`define MODEXP_MODULUS 65521

// R^2 mod m with R = 2^16 (R mod m is 15)
`define MODEXP_RHO 225

`endif

/* hw/modexp_pkg.sv */
`include "modexp_macros.svh"

package modexp_pkg;

    // one residue word
    typedef logic [`MODEXP_OPW-1:0] operand_t;

    // exponent word captured on start
    typedef logic [`MODEXP_EXPW-1:0] exponent_t;

    // controller phases
    //   idle      : waiting for start
    //   to_mont   : acc and base enter the Montgomery domain
    //   ladder    : one round per exponent bit, LSB first
    //   from_mont : acc leaves the Montgomery domain
    typedef enum logic [1:0] {
        idle,
        to_mont,
        ladder,
        from_mont
    } modexp_phase_t;

endpackage

/* hw/mont_mul.sv */
`timescale 1ns/10ps
`include "modexp_macros.svh"

// bit-serial radix-2 Montgomery multiplier, product = a*b*R^-1 mod m
module mont_mul import modexp_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  operand_t a,
    input  operand_t b,
    output operand_t product,
    output logic     done
);

    logic [`MODEXP_OPW+1:0]         modulus;
    operand_t                       a_q;
    operand_t                       b_q;
    logic [`MODEXP_OPW:0]           sum_q;
    logic [`MODEXP_OPW+1:0]         add_b;
    logic [`MODEXP_OPW+1:0]         add_m;
    logic [`MODEXP_OPW:0]           sum_next;
    logic [`MODEXP_OPW+1:0]         reduced;
    operand_t                       final_res;
    logic [$clog2(`MODEXP_OPW)-1:0] step_cnt;
    logic                           running;
    logic                           last_step;

    assign modulus = (`MODEXP_OPW+2)'(`MODEXP_MODULUS);

    // ------------------------------------------------------------------
    // one step: add b on a set bit, make even with m, halve
    // ------------------------------------------------------------------
    // sum stays below m + b, so one extra bit is enough
    assign add_b    = {1'b0, sum_q} + (a_q[0] ? {2'b00, b_q} : '0);
    assign add_m    = add_b + (add_b[0] ? modulus : '0);
    assign sum_next = add_m[`MODEXP_OPW+1:1];

    // single conditional subtraction after the last step
    assign reduced   = {1'b0, sum_next} - modulus;
    assign final_res = reduced[`MODEXP_OPW+1] ? sum_next[`MODEXP_OPW-1:0]
                                              : reduced[`MODEXP_OPW-1:0];

    assign last_step = running && (step_cnt == '1);

    // step counter and done strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= last_step;
            if (start) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (last_step) begin
                running <= 1'b0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // operand latch and partial sum
    always_ff @(posedge clk) begin
        if (start) begin
            a_q   <= a;
            b_q   <= b;
            sum_q <= '0;
        end else if (running) begin
            a_q   <= a_q >> 1;
            sum_q <= sum_next;
        end
        if (last_step) begin
            product <= final_res;
        end
    end

endmodule

/* hw/modexp_ctrl.sv */
`timescale 1ns/10ps
`include "modexp_macros.svh"

// phase sequencer for right-to-left square-and-multiply
module modexp_ctrl import modexp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  operand_t  base,
    input  exponent_t exponent,
    input  operand_t  acc_product,
    input  operand_t  sq_product,
    input  logic      acc_done,
    output logic      acc_start,
    output logic      sq_start,
    output operand_t  acc_a,
    output operand_t  acc_b,
    output operand_t  sq_a,
    output operand_t  sq_b,
    output logic      busy,
    output logic      result_valid,
    output operand_t  result
);

    modexp_phase_t                   phase;
    exponent_t                       exp_q;
    logic [$clog2(`MODEXP_EXPW)-1:0] bit_cnt;
    logic                            last_round;
    operand_t                        acc_q;
    operand_t                        base_q;

    assign busy       = (phase != idle);
    assign last_round = (bit_cnt == ($clog2(`MODEXP_EXPW))'(`MODEXP_EXPW - 1));

    // ------------------------------------------------------------------
    // operand select, held stable for a whole multiply
    // ------------------------------------------------------------------
    always_comb begin
        acc_a = acc_q;
        acc_b = base_q;
        sq_a  = base_q;
        sq_b  = base_q;
        case (phase)
            to_mont: begin
                // acc <- R mod m, base <- x*R mod m
                acc_a = operand_t'(1);
                acc_b = operand_t'(`MODEXP_RHO);
                sq_b  = operand_t'(`MODEXP_RHO);
            end
            from_mont: begin
                acc_b = operand_t'(1);
            end
            default: begin
            end
        endcase
    end

    // ------------------------------------------------------------------
    // phase sequencing, strobes and result
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase        <= idle;
            bit_cnt      <= '0;
            acc_start    <= 1'b0;
            sq_start     <= 1'b0;
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            acc_start    <= 1'b0;
            sq_start     <= 1'b0;
            result_valid <= 1'b0;
            case (phase)
                idle: begin
                    if (start) begin
                        phase     <= to_mont;
                        bit_cnt   <= '0;
                        acc_start <= 1'b1;
                        sq_start  <= 1'b1;
                    end
                end
                to_mont: begin
                    if (acc_done) begin
                        phase     <= ladder;
                        acc_start <= 1'b1;
                        sq_start  <= 1'b1;
                    end
                end
                ladder: begin
                    // both multipliers run every round, so timing ignores the bit
                    if (acc_done) begin
                        acc_start <= 1'b1;
                        if (last_round) begin
                            phase <= from_mont;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            sq_start <= 1'b1;
                        end
                    end
                end
                from_mont: begin
                    // stay here through the strobe cycle so busy covers it
                    if (result_valid) begin
                        phase <= idle;
                    end else if (acc_done) begin
                        result       <= acc_product;
                        result_valid <= 1'b1;
                    end
                end
                default: begin
                    phase <= idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // residues and exponent shifter
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        case (phase)
            idle: begin
                if (start) begin
                    base_q <= base;
                    exp_q  <= exponent;
                end
            end
            to_mont: begin
                if (acc_done) begin
                    acc_q  <= acc_product;
                    base_q <= sq_product;
                end
            end
            ladder: begin
                if (acc_done) begin
                    base_q <= sq_product;
                    // accumulator product only counts on a set bit
                    if (exp_q[0]) begin
                        acc_q <= acc_product;
                    end
                    exp_q <= exp_q >> 1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/modexp_top.sv */
`timescale 1ns/10ps

// result = base^exponent mod m with two Montgomery multipliers
module modexp_top import modexp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  operand_t  base,
    input  exponent_t exponent,
    output logic      busy,
    output operand_t  result,
    output logic      result_valid
);

    logic     acc_start;
    logic     sq_start;
    operand_t acc_a;
    operand_t acc_b;
    operand_t sq_a;
    operand_t sq_b;
    operand_t acc_product;
    operand_t sq_product;
    logic     acc_done;

    modexp_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .base         (base),
        .exponent     (exponent),
        .acc_product  (acc_product),
        .sq_product   (sq_product),
        .acc_done     (acc_done),
        .acc_start    (acc_start),
        .sq_start     (sq_start),
        .acc_a        (acc_a),
        .acc_b        (acc_b),
        .sq_a         (sq_a),
        .sq_b         (sq_b),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    // conditional multiply into the accumulator
    mont_mul u_mul_acc (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (acc_start),
        .a       (acc_a),
        .b       (acc_b),
        .product (acc_product),
        .done    (acc_done)
    );

    // squaring of the base, started together with u_mul_acc
    mont_mul u_mul_sq (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (sq_start),
        .a       (sq_a),
        .b       (sq_b),
        .product (sq_product),
        .done    ()
    );

endmodule

/* verif/modexp_asserts.sv */
`timescale 1ns/10ps
`include "modexp_macros.svh"

// protocol checks on the controller, bound in from the testbench
module modexp_asserts import modexp_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input modexp_phase_t phase,
    input logic          acc_start,
    input logic          sq_start,
    input logic          acc_done,
    input logic          result_valid,
    input operand_t      result
);

    // ------------------------------------------------------------------
    // result strobe
    // ------------------------------------------------------------------
    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else $error("result_valid high for two cycles in a row");

    a_result_range: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result < operand_t'(`MODEXP_MODULUS)))
        else $error("result not reduced below the modulus");

    // ------------------------------------------------------------------
    // multiplier starts
    // ------------------------------------------------------------------
    // squaring never runs alone
    a_sq_with_acc: assert property (@(posedge clk) disable iff (!rst_n)
        sq_start |-> acc_start)
        else $error("sq_start without acc_start");

    // only the conversion out of the Montgomery domain runs acc alone
    a_acc_with_sq: assert property (@(posedge clk) disable iff (!rst_n)
        (acc_start && phase != from_mont) |-> sq_start)
        else $error("acc_start without sq_start outside from_mont");

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        acc_start |-> ##17 acc_done)
        else $error("acc_done did not follow acc_start after 17 cycles");

endmodule

/* verif/modexp_tb.sv */
`timescale 1ns/10ps
`include "modexp_macros.svh"

module modexp_tb import modexp_pkg::*; ();

    localparam int NUM_VECTORS   = 24;
    localparam int LATENCY       = 18 * 18;
    localparam int WAIT_LIMIT    = 330;
    localparam int CYCLE_LIMIT   = NUM_VECTORS * 330 + 100;
    localparam int INTRUDE_CYCLE = 100;

    localparam logic [31:0] MOD32 = 32'(`MODEXP_MODULUS);

    // each table row holds stimulus, expected result, idle gap before start
    // and whether a second start is pushed in mid-run
    typedef struct packed {
        operand_t   base;
        exponent_t  exponent;
        operand_t   expected;
        logic [1:0] gap;
        logic       intrude;
    } vector_t;

    logic      clk;
    logic      rst_n;
    logic      start;
    operand_t  base;
    exponent_t exponent;
    logic      busy;
    operand_t  result;
    logic      result_valid;

    vector_t     vectors [NUM_VECTORS];
    logic [15:0] lfsr_state;
    int          cycle_count = 0;

    modexp_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .base         (base),
        .exponent     (exponent),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    bind modexp_ctrl modexp_asserts u_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .phase        (phase),
        .acc_start    (acc_start),
        .sq_start     (sq_start),
        .acc_done     (acc_done),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // failure handling and compare tasks
    // ------------------------------------------------------------------
    task automatic halt_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on a failure");
    endtask

    task automatic check_operand(input string name, input operand_t got, input operand_t exp);
        if (got !== exp) begin
            $display("Fail time %0t: %s got %0d expected %0d", $time, name, got, exp);
            halt_on_failure();
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail time %0t: %s got %0d expected %0d", $time, name, got, exp);
            halt_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail time %0t: %s got %b expected %b", $time, name, got, exp);
            halt_on_failure();
        end
    endtask

    // whole-run guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("run did not finish within %0d clock cycles", CYCLE_LIMIT);
            halt_on_failure();
        end
    end

    // ------------------------------------------------------------------
    // reference model and random source
    // ------------------------------------------------------------------
    // plain right-to-left square-and-multiply without Montgomery form
    function automatic operand_t model_modexp(input operand_t b, input exponent_t e);
        logic [31:0] r;
        logic [31:0] x;
        r = 32'd1 % MOD32;
        x = 32'(b) % MOD32;
        for (int i = 0; i < `MODEXP_EXPW; i++) begin
            if (e[i]) begin
                r = (r * x) % MOD32;
            end
            x = (x * x) % MOD32;
        end
        return operand_t'(r);
    endfunction

    // taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
    function automatic logic [15:0] lfsr_word();
        logic        fb;
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            w          = {w[14:0], fb};
        end
        return w;
    endfunction

    task automatic load_vector(input int idx, input operand_t b, input exponent_t e,
                               input logic [1:0] gap, input logic intrude);
        vectors[idx].base     = b;
        vectors[idx].exponent = e;
        vectors[idx].expected = model_modexp(b, e);
        vectors[idx].gap      = gap;
        vectors[idx].intrude  = intrude;
    endtask

    task automatic build_table();
        logic [15:0] b_rand;
        logic [15:0] e_rand;
        // fixed corner cases
        load_vector(0, 16'd1234, 16'd0, 2'd3, 1'b0);
        load_vector(1, 16'd0, 16'd77, 2'd1, 1'b0);
        load_vector(2, 16'd1, 16'hBEEF, 2'd2, 1'b0);
        load_vector(3, 16'd65530, 16'd1000, 2'd1, 1'b1);
        load_vector(4, 16'd3, 16'hFFFF, 2'd0, 1'b0);
        load_vector(5, 16'd65520, 16'd5, 2'd2, 1'b0);
        load_vector(6, 16'd65520, 16'd6, 2'd1, 1'b0);
        load_vector(7, 16'd2, 16'h8001, 2'd3, 1'b1);
        // entry 12 of the random rows starts right after the previous strobe
        for (int i = 8; i < NUM_VECTORS; i++) begin
            b_rand = lfsr_word();
            e_rand = lfsr_word();
            load_vector(i, b_rand, e_rand, (i == 12) ? 2'd0 : 2'd2, (i == 15));
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    // inputs change and outputs are sampled 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic run_entry(input int idx);
        vector_t v;
        int      cycles;
        v = vectors[idx];
        repeat (v.gap) next_cycle();
        check_flag("busy", busy, 1'b0);
        start    = 1'b1;
        base     = v.base;
        exponent = v.exponent;
        next_cycle();
        start    = 1'b0;
        base     = '0;
        exponent = '0;
        cycles   = 0;
        while (result_valid !== 1'b1) begin
            check_flag("busy", busy, 1'b1);
            if (cycles >= WAIT_LIMIT) begin
                $display("no result_valid within %0d cycles for vector %0d", WAIT_LIMIT, idx);
                halt_on_failure();
            end
            // a second start while busy must not disturb the run
            if (v.intrude && cycles == INTRUDE_CYCLE) begin
                start    = 1'b1;
                base     = ~v.base;
                exponent = ~v.exponent;
            end else begin
                start    = 1'b0;
                base     = '0;
                exponent = '0;
            end
            next_cycle();
            cycles++;
        end
        check_flag("busy", busy, 1'b1);
        check_cycles("result_valid latency", cycles, LATENCY);
        check_operand("result", result, v.expected);
        next_cycle();
        check_flag("result_valid", result_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_operand("result", result, v.expected);
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        base       = '0;
        exponent   = '0;
        lfsr_state = 16'd52;
        build_table();

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flag("busy", busy, 1'b0);
        check_flag("result_valid", result_valid, 1'b0);
        check_operand("result", result, '0);

        for (int idx = 0; idx < NUM_VECTORS; idx++) begin
            run_entry(idx);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hw
hw/modexp_pkg.sv
hw/mont_mul.sv
hw/modexp_ctrl.sv
hw/modexp_top.sv
verif/modexp_asserts.sv
verif/modexp_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the modexp testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module modexp_tb -f tb.f -o modexp_sim \
    && ./obj_dir/modexp_sim \
    || exit 1
